//--- rtl/cachePkg.sv
package cachePkg;

	// ------------------------------------------------------------
	// geometry
	// ------------------------------------------------------------
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int lineWidth = 256;
	localparam int wordsPerLine = lineWidth / wordWidth;
	localparam int offsetBits = $clog2(lineWidth / 8); // byte offset in a line
	localparam int wordSelBits = $clog2(wordsPerLine);

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [wordsPerLine-1:0][wordWidth-1:0] line_t; // word 0 in low bits
	typedef logic [addrWidth-1:0] addr_t;
	typedef logic way_t;

	// ------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		opNone       = 2'd0,
		opRead       = 2'd1,
		opWrite      = 2'd2,
		opInvalidate = 2'd3
	} cacheOp_t;

	typedef enum logic [2:0] {
		stIdle,
		stLookup,
		stWriteBack,
		stWaitWrite,
		stFill,
		stWaitFill,
		stDone
	} ctrlState_t;

endpackage

//--- rtl/wayLookupIf.sv
`timescale 1ns/100ps

interface wayLookupIf import cachePkg::*; #(
	parameter int indexBits = 4
) ();
	localparam int tagWidth = addrWidth - indexBits - offsetBits;

	// request side, shared by both stores
	logic [indexBits-1:0] index;
	logic [tagWidth-1:0] lookupTag;
	way_t accessWay;
	logic [wordSelBits-1:0] wordSel;

	// tag store answers
	logic hitValid;
	way_t hitWay;
	way_t victimWay;
	logic victimDirty; // line in accessWay is valid and dirty
	logic [tagWidth-1:0] victimTag;

	// update strobes, all act on accessWay
	logic fillLine;
	logic markDirty;
	logic touch;
	logic clearDirty;
	logic clearValid;

	// data path
	logic writeWord;
	word_t storeWord;
	line_t fillData;
	word_t loadWord;
	line_t victimLine;

	modport controller (
		output index, lookupTag, accessWay, wordSel,
		output fillLine, markDirty, touch, clearDirty, clearValid,
		output writeWord, storeWord, fillData,
		input hitValid, hitWay, victimWay, victimDirty, victimTag,
		input loadWord, victimLine
	);

	modport tags (
		input index, lookupTag, accessWay,
		input fillLine, markDirty, touch, clearDirty, clearValid,
		output hitValid, hitWay, victimWay, victimDirty, victimTag
	);

	modport data (
		input index, accessWay, wordSel, writeWord, storeWord, fillData, fillLine,
		output loadWord, victimLine
	);

endinterface

//--- rtl/tagStore.sv
`timescale 1ns/100ps

module tagStore import cachePkg::*; #(
	parameter int indexBits = 4
) (
	input logic clk,
	input logic reset,
	wayLookupIf.tags lookup
);
	localparam int tagWidth = addrWidth - indexBits - offsetBits;
	localparam int numSets = 1 << indexBits;

	logic [tagWidth-1:0] tagMem [2][numSets];
	logic [1:0] validMem [numSets];
	logic [1:0] dirtyMem [numSets];
	way_t lruMem [numSets]; // least recently used way
	logic [indexBits-1:0] clearIdx;
	logic [indexBits-1:0] idx;
	logic [1:0] wayHit;
	way_t way;

	assign idx = lookup.index;
	assign way = lookup.accessWay;

	// ------------------------------------------------------------
	// lookup, purely combinational
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = validMem[idx][w] && (tagMem[w][idx] == lookup.lookupTag);
		end
	end

	assign lookup.hitValid = |wayHit;
	assign lookup.hitWay = way_t'(wayHit[1]);

	// empty way first, else the older one
	always_comb begin
		if (!validMem[idx][0]) begin
			lookup.victimWay = 1'b0;
		end else if (!validMem[idx][1]) begin
			lookup.victimWay = 1'b1;
		end else begin
			lookup.victimWay = lruMem[idx];
		end
	end

	assign lookup.victimDirty = validMem[idx][way] & dirtyMem[idx][way];
	assign lookup.victimTag = tagMem[way][idx];

	// ------------------------------------------------------------
	// updates
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			validMem[clearIdx] <= 2'b00; // walks one set per cycle
			clearIdx <= clearIdx + 1'b1;
		end else begin
			if (lookup.fillLine) begin
				tagMem[way][idx] <= lookup.lookupTag;
				validMem[idx][way] <= 1'b1;
				dirtyMem[idx][way] <= 1'b0;
			end
			if (lookup.markDirty) begin
				dirtyMem[idx][way] <= 1'b1;
			end
			if (lookup.clearDirty) begin
				dirtyMem[idx][way] <= 1'b0;
			end
			if (lookup.clearValid) begin
				validMem[idx][way] <= 1'b0;
			end
			if (lookup.fillLine || lookup.touch) begin
				lruMem[idx] <= ~way; // other way is now older
			end
		end
	end

endmodule

//--- rtl/dataStore.sv
`timescale 1ns/100ps

module dataStore import cachePkg::*; #(
	parameter int indexBits = 4
) (
	input logic clk,
	wayLookupIf.data lookup
);
	localparam int numSets = 1 << indexBits;

	line_t lineMem [2][numSets];
	line_t curLine;
	logic [indexBits-1:0] idx;
	way_t way;

	assign idx = lookup.index;
	assign way = lookup.accessWay;

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	assign curLine = lineMem[way][idx];
	assign lookup.victimLine = curLine; // whole line for writeback
	assign lookup.loadWord = curLine[lookup.wordSel];

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (lookup.fillLine) begin
			lineMem[way][idx] <= lookup.fillData;
		end else if (lookup.writeWord) begin
			lineMem[way][idx][lookup.wordSel] <= lookup.storeWord;
		end
	end

endmodule

//--- rtl/cacheController.sv
`timescale 1ns/100ps

module cacheController import cachePkg::*; #(
	parameter int indexBits = 4
) (
	input logic clk,
	input logic reset,
	input cacheOp_t op,
	input addr_t addr,
	input word_t writeData,
	output logic done,
	output logic hit,
	output word_t readData,
	output logic memReadReq,
	output addr_t memReadAddr,
	input logic memReadValid,
	input line_t memReadLine,
	output logic memWriteReq,
	output addr_t memWriteAddr,
	output line_t memWriteLine,
	input logic memWriteDone,
	wayLookupIf.controller lookup
);
	localparam int tagWidth = addrWidth - indexBits - offsetBits;

	ctrlState_t state;
	logic memUsed; // sticky, any memory traffic in this op
	logic [tagWidth-1:0] reqTag;
	logic [indexBits-1:0] reqIndex;
	logic isInval;

	assign reqTag = addr[addrWidth-1 -: tagWidth];
	assign reqIndex = addr[offsetBits +: indexBits];
	assign isInval = (op == opInvalidate);

	assign lookup.index = reqIndex;
	assign lookup.lookupTag = reqTag;
	assign lookup.wordSel = addr[offsetBits-1 -: wordSelBits];
	assign lookup.accessWay = lookup.hitValid ? lookup.hitWay : lookup.victimWay;
	assign lookup.storeWord = writeData;
	assign lookup.fillData = memReadLine;

	assign done = (state == stDone);
	assign hit = ~memUsed;

	// ------------------------------------------------------------
	// store strobes
	// ------------------------------------------------------------
	always_comb begin
		lookup.fillLine = 1'b0;
		lookup.markDirty = 1'b0;
		lookup.touch = 1'b0;
		lookup.clearDirty = 1'b0;
		lookup.clearValid = 1'b0;
		lookup.writeWord = 1'b0;
		case (state)
			stLookup: if (lookup.hitValid) begin
				if (isInval) begin
					lookup.clearValid = ~lookup.victimDirty; // dirty goes out first
				end else begin
					lookup.touch = 1'b1;
					lookup.writeWord = (op == opWrite);
					lookup.markDirty = (op == opWrite);
				end
			end
			stWaitWrite: if (memWriteDone) begin
				lookup.clearDirty = 1'b1;
				lookup.clearValid = isInval;
			end
			stWaitFill: lookup.fillLine = memReadValid;
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			memUsed <= 1'b0;
			memReadReq <= 1'b0;
			memWriteReq <= 1'b0;
		end else begin
			memReadReq <= 1'b0;
			memWriteReq <= 1'b0;
			case (state)
				stIdle: begin
					memUsed <= 1'b0;
					if (op != opNone) state <= stLookup;
				end
				stLookup: begin
					if (lookup.hitValid && !(isInval && lookup.victimDirty)) begin
						state <= stDone;
					end else if (!lookup.hitValid && isInval) begin
						state <= stDone; // nothing to drop
					end else if (lookup.victimDirty) begin
						state <= stWriteBack;
					end else begin
						state <= stFill;
					end
				end
				stWriteBack: begin
					memWriteReq <= 1'b1;
					memUsed <= 1'b1;
					state <= stWaitWrite;
				end
				stWaitWrite: if (memWriteDone) state <= isInval ? stDone : stFill;
				stFill: begin
					memReadReq <= 1'b1;
					memUsed <= 1'b1;
					state <= stWaitFill;
				end
				stWaitFill: if (memReadValid) state <= stLookup; // retry, hits now
				default: state <= stIdle; // stDone
			endcase
		end
	end

	// payload, held until the answer comes back
	always_ff @(posedge clk) begin
		if (state == stLookup && lookup.hitValid) readData <= lookup.loadWord;
		if (state == stWriteBack) begin
			memWriteAddr <= {lookup.victimTag, reqIndex, {offsetBits{1'b0}}};
			memWriteLine <= lookup.victimLine;
		end
		if (state == stFill) memReadAddr <= {reqTag, reqIndex, {offsetBits{1'b0}}};
	end

endmodule

//--- rtl/setAssocCache.sv
`timescale 1ns/100ps

module setAssocCache import cachePkg::*; #(
	parameter int indexBits = 4
) (
	input logic clk,
	input logic reset,
	input cacheOp_t op,
	input addr_t addr,
	input word_t writeData,
	output logic done,
	output logic hit,
	output word_t readData,
	output logic memReadReq,
	output addr_t memReadAddr,
	input logic memReadValid,
	input line_t memReadLine,
	output logic memWriteReq,
	output addr_t memWriteAddr,
	output line_t memWriteLine,
	input logic memWriteDone
);

	wayLookupIf #(.indexBits(indexBits)) lookupBus ();

	cacheController #(.indexBits(indexBits)) ctrl (
		.clk          (clk),
		.reset        (reset),
		.op           (op),
		.addr         (addr),
		.writeData    (writeData),
		.done         (done),
		.hit          (hit),
		.readData     (readData),
		.memReadReq   (memReadReq),
		.memReadAddr  (memReadAddr),
		.memReadValid (memReadValid),
		.memReadLine  (memReadLine),
		.memWriteReq  (memWriteReq),
		.memWriteAddr (memWriteAddr),
		.memWriteLine (memWriteLine),
		.memWriteDone (memWriteDone),
		.lookup       (lookupBus.controller)
	);

	tagStore #(.indexBits(indexBits)) tags (
		.clk    (clk),
		.reset  (reset),
		.lookup (lookupBus.tags)
	);

	dataStore #(.indexBits(indexBits)) lines (
		.clk    (clk),
		.lookup (lookupBus.data)
	);

endmodule

//--- test/memModel.sv
`timescale 1ns/100ps

module memModel import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic memReadReq,
	input addr_t memReadAddr,
	output logic memReadValid,
	output line_t memReadLine,
	input logic memWriteReq,
	input addr_t memWriteAddr,
	input line_t memWriteLine,
	output logic memWriteDone,
	output int writeBackCount
);
	line_t written [addr_t]; // lines that came back from the cache
	integer seed;
	int latency;
	logic isRead; // kind of the request being answered

	// word address with its upper 16 bits flipped
	function automatic line_t initialLine(addr_t lineAddr);
		line_t l;
		for (int w = 0; w < wordsPerLine; w++) begin
			l[w] = ((lineAddr + addr_t'(w * 4)) >> 2) ^ 32'hffff_0000;
		end
		return l;
	endfunction

	// ------------------------------------------------------------
	// one request at a time, answered after 1 to 8 cycles
	// ------------------------------------------------------------
	initial begin
		seed = 32'hdb0b;
		memReadValid = 1'b0;
		memReadLine = '0;
		memWriteDone = 1'b0;
		writeBackCount = 0;
		forever begin
			@(posedge clk);
			if (!reset && (memWriteReq || memReadReq)) begin
				latency = ($random(seed) & 7) + 1;
				isRead = memReadReq;
				if (memWriteReq) begin
					written[memWriteAddr] = memWriteLine;
					writeBackCount++;
				end
				repeat (latency - 1) @(posedge clk);
				#2;
				if (isRead) begin
					memReadLine = written.exists(memReadAddr) ? written[memReadAddr]
						: initialLine(memReadAddr);
					memReadValid = 1'b1;
				end else begin
					memWriteDone = 1'b1;
				end
				@(posedge clk);
				#2;
				memReadValid = 1'b0;
				memWriteDone = 1'b0;
			end
		end
	end

endmodule

//--- test/cacheTb.sv
`timescale 1ns/100ps

module cacheTb import cachePkg::*; ();

	typedef struct {
		cacheOp_t op;
		addr_t addr;
		word_t data;
		logic expHit;
		word_t expData;
		int expReqs; // memory requests during this row
		int expWb; // writebacks since reset
	} row_t;

	logic clk;
	logic reset;
	cacheOp_t op;
	addr_t addr;
	word_t writeData;
	logic done;
	logic hit;
	word_t readData;
	logic memReadReq;
	addr_t memReadAddr;
	logic memReadValid;
	line_t memReadLine;
	logic memWriteReq;
	addr_t memWriteAddr;
	line_t memWriteLine;
	logic memWriteDone;
	int wbCount;

	row_t rows[$];
	int reqTotal;
	int cycleCount;

	setAssocCache #(.indexBits(4)) dut (
		.clk          (clk),
		.reset        (reset),
		.op           (op),
		.addr         (addr),
		.writeData    (writeData),
		.done         (done),
		.hit          (hit),
		.readData     (readData),
		.memReadReq   (memReadReq),
		.memReadAddr  (memReadAddr),
		.memReadValid (memReadValid),
		.memReadLine  (memReadLine),
		.memWriteReq  (memWriteReq),
		.memWriteAddr (memWriteAddr),
		.memWriteLine (memWriteLine),
		.memWriteDone (memWriteDone)
	);

	memModel mem (
		.clk            (clk),
		.reset          (reset),
		.memReadReq     (memReadReq),
		.memReadAddr    (memReadAddr),
		.memReadValid   (memReadValid),
		.memReadLine    (memReadLine),
		.memWriteReq    (memWriteReq),
		.memWriteAddr   (memWriteAddr),
		.memWriteLine   (memWriteLine),
		.memWriteDone   (memWriteDone),
		.writeBackCount (wbCount)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------
	// request counting and run limit
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (memReadReq) reqTotal++;
		if (memWriteReq) reqTotal++;
		cycleCount++;
		if (cycleCount > rows.size() * 40) begin
			$display("timeout: the cache did not finish its operations in time");
			$display("Simulation failed");
			$fatal(1, "run limit reached");
		end
	end

	// initial memory content, as seen by the requester
	function automatic word_t ruleWord(addr_t a);
		return (a >> 2) ^ 32'hffff_0000;
	endfunction

	task automatic checkValue(string what, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic addRow(cacheOp_t rowOp, addr_t rowAddr, word_t rowData, logic expHit,
			word_t expData, int expReqs, int expWb);
		row_t r;
		r.op = rowOp;
		r.addr = rowAddr;
		r.data = rowData;
		r.expHit = expHit;
		r.expData = expData;
		r.expReqs = expReqs;
		r.expWb = expWb;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		// one line in set 0
		addRow(opRead, 32'h0000_1004, 32'h0, 1'b0, ruleWord(32'h0000_1004), 1, 0);
		addRow(opRead, 32'h0000_1018, 32'h0, 1'b1, ruleWord(32'h0000_1018), 0, 0);
		addRow(opWrite, 32'h0000_1008, 32'hcafe_0001, 1'b1, 32'h0, 0, 0);
		addRow(opRead, 32'h0000_1008, 32'h0, 1'b1, 32'hcafe_0001, 0, 0);
		// ------------------------------------------------------------
		// set 2, LRU replacement
		// ------------------------------------------------------------
		addRow(opRead, 32'h0000_2040, 32'h0, 1'b0, ruleWord(32'h0000_2040), 1, 0);
		addRow(opRead, 32'h0000_2240, 32'h0, 1'b0, ruleWord(32'h0000_2240), 1, 0);
		addRow(opRead, 32'h0000_2040, 32'h0, 1'b1, ruleWord(32'h0000_2040), 0, 0);
		addRow(opRead, 32'h0000_2440, 32'h0, 1'b0, ruleWord(32'h0000_2440), 1, 0);
		addRow(opRead, 32'h0000_2040, 32'h0, 1'b1, ruleWord(32'h0000_2040), 0, 0);
		addRow(opRead, 32'h0000_2240, 32'h0, 1'b0, ruleWord(32'h0000_2240), 1, 0);
		// set 3, dirty victim goes back to memory
		addRow(opWrite, 32'h0000_3060, 32'h0bad_f00d, 1'b0, 32'h0, 1, 0);
		addRow(opRead, 32'h0000_3260, 32'h0, 1'b0, ruleWord(32'h0000_3260), 1, 0);
		addRow(opRead, 32'h0000_3460, 32'h0, 1'b0, ruleWord(32'h0000_3460), 2, 1);
		addRow(opRead, 32'h0000_3060, 32'h0, 1'b0, 32'h0bad_f00d, 1, 1);
		// set 4, clean and dirty invalidate
		addRow(opRead, 32'h0000_4080, 32'h0, 1'b0, ruleWord(32'h0000_4080), 1, 1);
		addRow(opInvalidate, 32'h0000_4080, 32'h0, 1'b1, 32'h0, 0, 1);
		addRow(opRead, 32'h0000_4080, 32'h0, 1'b0, ruleWord(32'h0000_4080), 1, 1);
		addRow(opWrite, 32'h0000_4084, 32'h5a5a_1234, 1'b1, 32'h0, 0, 1);
		addRow(opInvalidate, 32'h0000_4084, 32'h0, 1'b0, 32'h0, 1, 2);
		addRow(opRead, 32'h0000_4084, 32'h0, 1'b0, 32'h5a5a_1234, 1, 2);
		addRow(opInvalidate, 32'h7000_00a0, 32'h0, 1'b1, 32'h0, 0, 2); // never cached
	endtask

	// entered 2 ns after a rising edge
	task automatic runRow(int i);
		row_t r;
		int reqStart;
		r = rows[i];
		reqStart = reqTotal;
		op = r.op;
		addr = r.addr;
		writeData = r.data;
		@(negedge clk);
		while (!done) @(negedge clk);
		checkValue($sformatf("row %0d hit", i), 32'(hit), 32'(r.expHit));
		if (r.op == opRead) begin
			checkValue($sformatf("row %0d readData", i), readData, r.expData);
		end
		checkValue($sformatf("row %0d memory requests", i), reqTotal - reqStart, r.expReqs);
		checkValue($sformatf("row %0d writebacks", i), wbCount, r.expWb);
		@(posedge clk);
		#2;
		op = opNone;
		@(posedge clk);
		#2;
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		reset = 1'b1;
		op = opNone;
		addr = '0;
		writeData = '0;
		reqTotal = 0;
		cycleCount = 0;
		buildTable();
		repeat (16) @(posedge clk); // one set cleared per cycle
		#2;
		reset = 1'b0;
		@(posedge clk);
		#2;
		foreach (rows[i]) runRow(i);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- files.f
rtl/cachePkg.sv
rtl/wayLookupIf.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/cacheController.sv
rtl/setAssocCache.sv
test/memModel.sv
test/cacheTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = cacheTb
FILELIST  = files.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
